/* source/bypass_pkg.sv */
package bypass_pkg;

    // Datapath and queue sizing
    localparam int data_width  = 64;   // One payload word per flit
    localparam int queue_depth = 4;
    localparam int ptr_width   = 2;
    localparam int stamp_width = 16;   // Cycle stamps and latencies

    typedef enum logic [1:0] {
        flit_mgmt,
        flit_ctrl,
        flit_protocol,
        flit_data
    } flit_type_t;

    typedef enum logic [1:0] {
        proto_cxl,
        proto_pcie,
        proto_other0,
        proto_other1
    } protocol_id_t;

    typedef struct packed {
        flit_type_t   flit_type;
        protocol_id_t protocol_id;
        logic [7:0]   tag;
    } flit_header_t;

    // Priority levels where higher wins
    localparam logic [2:0] prio_mgmt        = 3'd7;
    localparam logic [2:0] prio_ctrl        = 3'd6;
    localparam logic [2:0] prio_cxl         = 3'd5;
    localparam logic [2:0] prio_pcie        = 3'd4;
    localparam logic [2:0] prio_proto_other = 3'd3;
    localparam logic [2:0] prio_data        = 3'd2;
    localparam logic [2:0] prio_max         = 3'd7;
    localparam logic [2:0] bypass_min_prio  = 3'd5;  // Eligibility threshold

    // Utilization window of 2**util_period_bits cycles
    localparam int util_period_bits = 8;
    localparam int percent_scale    = 100;

    typedef struct packed {
        logic [data_width-1:0]  data;
        flit_header_t           header;
        logic [stamp_width-1:0] stamp;
        logic                   eligible;
    } bypass_entry_t;

    typedef struct packed {
        logic [data_width-1:0]  data;
        flit_header_t           header;
        logic [stamp_width-1:0] stamp;
    } normal_entry_t;

endpackage

/* source/flit_classifier.sv */
`timescale 1ns/1ps

module flit_classifier (
    input  logic                   clk_quarter_rate,
    input  logic                   rst_n,
    input  bypass_pkg::flit_header_t header,
    input  logic                   accept,
    input  logic                   hint_enable,
    input  logic [7:0]             latency_prediction,
    input  logic [7:0]             latency_threshold,
    input  logic [7:0]             utilization,
    input  logic [7:0]             utilization_limit,
    output logic                   eligible,
    output logic [2:0]             active_priority
);

    logic [2:0] base_prio;
    logic [2:0] final_prio;
    logic       hint_hit;
    logic       throttled;

    // Header to base priority
    always_comb begin
        case (header.flit_type)
            bypass_pkg::flit_mgmt: base_prio = bypass_pkg::prio_mgmt;
            bypass_pkg::flit_ctrl: base_prio = bypass_pkg::prio_ctrl;
            bypass_pkg::flit_protocol: begin
                case (header.protocol_id)
                    bypass_pkg::proto_cxl:  base_prio = bypass_pkg::prio_cxl;
                    bypass_pkg::proto_pcie: base_prio = bypass_pkg::prio_pcie;
                    default:                base_prio = bypass_pkg::prio_proto_other;
                endcase
            end
            default: base_prio = bypass_pkg::prio_data;
        endcase
    end

    assign hint_hit  = hint_enable && (latency_prediction < latency_threshold);
    assign throttled = utilization > utilization_limit;

    // Saturating bump when the predicted latency is short
    always_comb begin
        final_prio = base_prio;
        if (hint_hit && (base_prio != bypass_pkg::prio_max)) begin
            final_prio = base_prio + 3'd1;
        end
    end

    assign eligible = ((final_prio >= bypass_pkg::bypass_min_prio) || hint_hit) && !throttled;

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            active_priority <= 3'd0;
        end else if (accept) begin
            active_priority <= final_prio;  // Priority of the flit just taken
        end
    end

    // Every accepted flit leaves a legal priority behind
    assert property (@(posedge clk_quarter_rate) disable iff (!rst_n)
        accept |=> (active_priority >= bypass_pkg::prio_data));

endmodule

/* source/flit_queue.sv */
`timescale 1ns/1ps

module flit_queue #(
    parameter type entry_t = logic
) (
    input  logic   clk_quarter_rate,
    input  logic   rst_n,
    input  logic   push,
    input  entry_t push_entry,
    input  logic   pop,
    output entry_t head,
    output logic   full,
    output logic   empty
);

    entry_t                         mem [bypass_pkg::queue_depth];
    logic [bypass_pkg::ptr_width-1:0] wr_ptr;
    logic [bypass_pkg::ptr_width-1:0] rd_ptr;
    logic [bypass_pkg::ptr_width:0]   count;  // One extra bit to tell full from empty

    // Storage written on push only
    always_ff @(posedge clk_quarter_rate) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign full  = (count == (bypass_pkg::ptr_width + 1)'(bypass_pkg::queue_depth));
    assign empty = (count == '0);

    // Upstream ready and arbiter pick must respect occupancy
    assert property (@(posedge clk_quarter_rate) disable iff (!rst_n) push |-> !full);
    assert property (@(posedge clk_quarter_rate) disable iff (!rst_n) pop |-> !empty);

endmodule

/* source/egress_arbiter.sv */
`timescale 1ns/1ps

module egress_arbiter (
    input  logic                              clk_quarter_rate,
    input  logic                              rst_n,
    input  bypass_pkg::bypass_entry_t         bypass_head,
    input  logic                              bypass_empty,
    input  bypass_pkg::normal_entry_t         normal_head,
    input  logic                              normal_empty,
    input  logic                              mux_ready,
    output logic                              bypass_pop,
    output logic                              normal_pop,
    output logic [bypass_pkg::data_width-1:0] mux_data,
    output bypass_pkg::flit_header_t          mux_header,
    output logic                              mux_valid,
    output logic                              mux_from_bypass,
    output logic                              grant,
    output logic                              grant_bypass,
    output logic [bypass_pkg::stamp_width-1:0] grant_stamp
);

    logic slot_free;
    logic pick;
    logic take_bypass;

    // Output register empty or draining on this edge
    assign slot_free = !mux_valid || mux_ready;
    assign pick      = slot_free && (!bypass_empty || !normal_empty);

    // Eligible bypass first, then normal, then whatever bypass holds
    always_comb begin
        if (!bypass_empty && bypass_head.eligible) begin
            take_bypass = 1'b1;
        end else if (!normal_empty) begin
            take_bypass = 1'b0;
        end else begin
            take_bypass = 1'b1;
        end
    end

    assign bypass_pop = pick && take_bypass;
    assign normal_pop = pick && !take_bypass;

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            mux_valid <= 1'b0;
            grant     <= 1'b0;
        end else begin
            grant <= pick;  // One pulse per pick
            if (pick) begin
                mux_valid <= 1'b1;
            end else if (mux_ready) begin
                mux_valid <= 1'b0;
            end
        end
    end

    // Payload side of the hold register
    always_ff @(posedge clk_quarter_rate) begin
        if (pick) begin
            mux_from_bypass <= take_bypass;
            grant_bypass    <= take_bypass;
            if (take_bypass) begin
                mux_data    <= bypass_head.data;
                mux_header  <= bypass_head.header;
                grant_stamp <= bypass_head.stamp;
            end else begin
                mux_data    <= normal_head.data;
                mux_header  <= normal_head.header;
                grant_stamp <= normal_head.stamp;
            end
        end
    end

    // Back-pressure holds the whole output
    assert property (@(posedge clk_quarter_rate) disable iff (!rst_n)
        (mux_valid && !mux_ready) |=>
            (mux_valid && $stable(mux_data) && $stable(mux_header) && $stable(mux_from_bypass)));

endmodule

/* source/bypass_monitor.sv */
`timescale 1ns/1ps

module bypass_monitor (
    input  logic                               clk_quarter_rate,
    input  logic                               rst_n,
    input  logic                               grant,
    input  logic                               grant_bypass,
    input  logic [bypass_pkg::stamp_width-1:0] grant_stamp,
    output logic [15:0]                        cycle_stamp,
    output logic [31:0]                        bypass_packets_count,
    output logic [31:0]                        normal_packets_count,
    output logic [15:0]                        bypass_latency_cycles,
    output logic [15:0]                        normal_latency_cycles,
    output logic [7:0]                         bypass_utilization_percent
);

    logic [15:0] grant_latency;
    logic [32:0] delivered_total;
    logic [39:0] bypass_scaled;
    logic [39:0] util_quotient;
    logic        period_end;

    // Free running stamp source
    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            cycle_stamp <= 16'd0;
        end else begin
            cycle_stamp <= cycle_stamp + 16'd1;
        end
    end

    assign grant_latency = cycle_stamp - grant_stamp;  // Wraps cleanly at 16 bits

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            bypass_packets_count  <= 32'd0;
            normal_packets_count  <= 32'd0;
            bypass_latency_cycles <= 16'd0;
            normal_latency_cycles <= 16'd0;
        end else if (grant) begin
            if (grant_bypass) begin
                bypass_packets_count  <= bypass_packets_count + 32'd1;
                bypass_latency_cycles <= grant_latency;
            end else begin
                normal_packets_count  <= normal_packets_count + 32'd1;
                normal_latency_cycles <= grant_latency;
            end
        end
    end

    // Share of bypass deliveries in percent
    assign delivered_total = {1'b0, bypass_packets_count} + {1'b0, normal_packets_count};
    assign bypass_scaled   = {8'd0, bypass_packets_count} * 40'(bypass_pkg::percent_scale);
    assign util_quotient   = bypass_scaled / {7'd0, delivered_total};
    assign period_end      = &cycle_stamp[bypass_pkg::util_period_bits-1:0];

    always_ff @(posedge clk_quarter_rate or negedge rst_n) begin
        if (!rst_n) begin
            bypass_utilization_percent <= 8'd0;
        end else if (period_end && (delivered_total != 33'd0)) begin
            bypass_utilization_percent <= util_quotient[7:0];  // Never above 100
        end
    end

endmodule

/* source/bypass_top.sv */
`timescale 1ns/1ps

module bypass_top (
    input  logic                              clk_quarter_rate,
    input  logic                              rst_n,
    input  logic                              bypass_enable,
    input  logic                              hint_enable,
    input  logic [7:0]                        latency_threshold,
    input  logic [7:0]                        utilization_limit,
    input  logic [7:0]                        latency_prediction,
    input  logic [bypass_pkg::data_width-1:0] bypass_data,
    input  bypass_pkg::flit_header_t          bypass_header,
    input  logic                              bypass_valid,
    output logic                              bypass_ready,
    input  logic [bypass_pkg::data_width-1:0] normal_data,
    input  bypass_pkg::flit_header_t          normal_header,
    input  logic                              normal_valid,
    output logic                              normal_ready,
    output logic [bypass_pkg::data_width-1:0] mux_data,
    output bypass_pkg::flit_header_t          mux_header,
    output logic                              mux_valid,
    output logic                              mux_from_bypass,
    input  logic                              mux_ready,
    output logic [2:0]                        active_priority,
    output logic [31:0]                       bypass_packets_count,
    output logic [31:0]                       normal_packets_count,
    output logic [15:0]                       bypass_latency_cycles,
    output logic [15:0]                       normal_latency_cycles,
    output logic [7:0]                        bypass_utilization_percent
);

    logic                               bypass_accept;
    logic                               normal_accept;
    logic                               bypass_full;
    logic                               bypass_empty;
    logic                               normal_full;
    logic                               normal_empty;
    logic                               bypass_pop;
    logic                               normal_pop;
    logic                               bypass_eligible;
    logic                               grant;
    logic                               grant_bypass;
    logic [bypass_pkg::stamp_width-1:0] grant_stamp;
    logic [15:0]                        cycle_stamp;
    bypass_pkg::bypass_entry_t          bypass_entry;
    bypass_pkg::bypass_entry_t          bypass_head;
    bypass_pkg::normal_entry_t          normal_entry;
    bypass_pkg::normal_entry_t          normal_head;

    // Ingress handshakes closed while disabled
    assign bypass_ready  = bypass_enable && !bypass_full;
    assign normal_ready  = bypass_enable && !normal_full;
    assign bypass_accept = bypass_valid && bypass_ready;
    assign normal_accept = normal_valid && normal_ready;

    assign bypass_entry = '{data: bypass_data, header: bypass_header,
                            stamp: cycle_stamp, eligible: bypass_eligible};
    assign normal_entry = '{data: normal_data, header: normal_header, stamp: cycle_stamp};

    flit_classifier flit_classifier_inst (
        .clk_quarter_rate   (clk_quarter_rate),
        .rst_n              (rst_n),
        .header             (bypass_header),
        .accept             (bypass_accept),
        .hint_enable        (hint_enable),
        .latency_prediction (latency_prediction),
        .latency_threshold  (latency_threshold),
        .utilization        (bypass_utilization_percent),
        .utilization_limit  (utilization_limit),
        .eligible           (bypass_eligible),
        .active_priority    (active_priority)
    );

    flit_queue #(.entry_t(bypass_pkg::bypass_entry_t)) bypass_queue_inst (
        .clk_quarter_rate (clk_quarter_rate),
        .rst_n            (rst_n),
        .push             (bypass_accept),
        .push_entry       (bypass_entry),
        .pop              (bypass_pop),
        .head             (bypass_head),
        .full             (bypass_full),
        .empty            (bypass_empty)
    );

    flit_queue #(.entry_t(bypass_pkg::normal_entry_t)) normal_queue_inst (
        .clk_quarter_rate (clk_quarter_rate),
        .rst_n            (rst_n),
        .push             (normal_accept),
        .push_entry       (normal_entry),
        .pop              (normal_pop),
        .head             (normal_head),
        .full             (normal_full),
        .empty            (normal_empty)
    );

    egress_arbiter egress_arbiter_inst (
        .clk_quarter_rate (clk_quarter_rate),
        .rst_n            (rst_n),
        .bypass_head      (bypass_head),
        .bypass_empty     (bypass_empty),
        .normal_head      (normal_head),
        .normal_empty     (normal_empty),
        .mux_ready        (mux_ready),
        .bypass_pop       (bypass_pop),
        .normal_pop       (normal_pop),
        .mux_data         (mux_data),
        .mux_header       (mux_header),
        .mux_valid        (mux_valid),
        .mux_from_bypass  (mux_from_bypass),
        .grant            (grant),
        .grant_bypass     (grant_bypass),
        .grant_stamp      (grant_stamp)
    );

    bypass_monitor bypass_monitor_inst (
        .clk_quarter_rate           (clk_quarter_rate),
        .rst_n                      (rst_n),
        .grant                      (grant),
        .grant_bypass               (grant_bypass),
        .grant_stamp                (grant_stamp),
        .cycle_stamp                (cycle_stamp),
        .bypass_packets_count       (bypass_packets_count),
        .normal_packets_count       (normal_packets_count),
        .bypass_latency_cycles      (bypass_latency_cycles),
        .normal_latency_cycles      (normal_latency_cycles),
        .bypass_utilization_percent (bypass_utilization_percent)
    );

endmodule

/* bench/bypass_tb.sv */
`timescale 1ns/1ps

module bypass_tb;

    localparam int random_cycles   = 3000;
    localparam int directed_cycles = 700;
    localparam int watchdog_cycles = (random_cycles + directed_cycles) * 4 + 2000;

    logic                              clk_quarter_rate;
    logic                              rst_n;
    logic                              bypass_enable;
    logic                              hint_enable;
    logic [7:0]                        latency_threshold;
    logic [7:0]                        utilization_limit;
    logic [7:0]                        latency_prediction;
    logic [bypass_pkg::data_width-1:0] bypass_data;
    bypass_pkg::flit_header_t          bypass_header;
    logic                              bypass_valid;
    logic                              bypass_ready;
    logic [bypass_pkg::data_width-1:0] normal_data;
    bypass_pkg::flit_header_t          normal_header;
    logic                              normal_valid;
    logic                              normal_ready;
    logic [bypass_pkg::data_width-1:0] mux_data;
    bypass_pkg::flit_header_t          mux_header;
    logic                              mux_valid;
    logic                              mux_from_bypass;
    logic                              mux_ready;
    logic [2:0]                        active_priority;
    logic [31:0]                       bypass_packets_count;
    logic [31:0]                       normal_packets_count;
    logic [15:0]                       bypass_latency_cycles;
    logic [15:0]                       normal_latency_cycles;
    logic [7:0]                        bypass_utilization_percent;

    integer      seed = 80;
    logic [75:0] exp_byp[$];     // Data above header
    logic [75:0] exp_norm[$];
    logic [75:0] exp_entry;
    int          m_byp;
    int          m_norm;
    logic [15:0] m_cycle;
    logic        m_started;
    logic [7:0]  m_util;
    logic        prio_pending;
    logic [2:0]  prio_expected;
    logic        prev_valid;
    logic        prev_consumed;
    logic        prev_hold;
    logic [63:0] held_data;
    logic [11:0] held_header;
    logic        held_from_bypass;
    int          order_mode;     // 1 bypass first, 2 normal first

    bypass_top bypass_top_inst (.*);

    initial begin
        clk_quarter_rate = 1'b0;
        forever #50 clk_quarter_rate = ~clk_quarter_rate;
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Priority rule of the classifier from header and hint inputs
    function automatic logic [2:0] expected_priority(input bypass_pkg::flit_header_t h,
                                                     input logic hint_on,
                                                     input logic [7:0] pred,
                                                     input logic [7:0] thresh);
        logic [2:0] p;
        case (h.flit_type)
            bypass_pkg::flit_mgmt: p = 3'd7;
            bypass_pkg::flit_ctrl: p = 3'd6;
            bypass_pkg::flit_protocol: begin
                if (h.protocol_id == bypass_pkg::proto_cxl) p = 3'd5;
                else if (h.protocol_id == bypass_pkg::proto_pcie) p = 3'd4;
                else p = 3'd3;
            end
            default: p = 3'd2;
        endcase
        if (hint_on && (pred < thresh) && (p != 3'd7)) begin
            p = p + 3'd1;  // Hint bump saturates at 7
        end
        return p;
    endfunction

    // Reference model sampled mid-cycle where everything is settled
    always @(negedge clk_quarter_rate) begin
        if (rst_n !== 1'b1) begin
            exp_byp.delete();
            exp_norm.delete();
            m_byp = 0;
            m_norm = 0;
            m_util = 8'd0;
            m_started = 1'b0;
            prio_pending = 1'b0;
            prev_valid = 1'b0;
            prev_consumed = 1'b0;
            prev_hold = 1'b0;
        end else begin
            m_cycle = m_started ? m_cycle + 16'd1 : 16'd0;
            m_started = 1'b1;
            check_equal(bypass_packets_count, m_byp, "bypass delivery count");
            check_equal(normal_packets_count, m_norm, "normal delivery count");
            check_equal(bypass_utilization_percent, m_util, "bypass utilization");
            if (m_byp != 0) check_equal(bypass_latency_cycles >= 16'd2, 1, "bypass latency");
            if (m_norm != 0) check_equal(normal_latency_cycles >= 16'd2, 1, "normal latency");
            if (!bypass_enable) begin
                check_equal(bypass_ready, 0, "bypass ready while disabled");
                check_equal(normal_ready, 0, "normal ready while disabled");
            end
            if (prio_pending) check_equal(active_priority, prio_expected, "active priority");
            prio_pending = 1'b0;
            if (prev_hold) begin
                check_equal(mux_valid, 1, "mux_valid dropped under back-pressure");
                check_equal(mux_data, held_data, "mux_data changed under back-pressure");
                check_equal(mux_header, held_header, "mux_header changed under back-pressure");
                check_equal(mux_from_bypass, held_from_bypass, "mux_from_bypass changed");
            end
            // Counts seen here are what the monitor uses on the coming edge
            if ((m_cycle[7:0] == 8'hff) && ((m_byp + m_norm) != 0)) begin
                m_util = 8'((m_byp * 100) / (m_byp + m_norm));
            end
            if (mux_valid && (!prev_valid || prev_consumed)) begin
                if (mux_from_bypass) begin
                    check_equal(exp_byp.size() != 0, 1, "bypass flit with none queued");
                    if (order_mode == 2) check_equal(exp_norm.size(), 0, "bypass overtook normal");
                    exp_entry = exp_byp.pop_front();
                    m_byp++;
                end else begin
                    check_equal(exp_norm.size() != 0, 1, "normal flit with none queued");
                    if (order_mode == 1) check_equal(exp_byp.size(), 0, "normal overtook bypass");
                    exp_entry = exp_norm.pop_front();
                    m_norm++;
                end
                check_equal(mux_data, exp_entry[75:12], "mux_data");
                check_equal(mux_header, exp_entry[11:0], "mux_header");
            end
            prev_valid = mux_valid;
            prev_consumed = mux_valid && mux_ready;
            prev_hold = mux_valid && !mux_ready;
            held_data = mux_data;
            held_header = mux_header;
            held_from_bypass = mux_from_bypass;
            // Flits taken on the coming edge
            if (bypass_valid && bypass_ready) begin
                exp_byp.push_back({bypass_data, bypass_header});
                prio_pending = 1'b1;
                prio_expected = expected_priority(bypass_header, hint_enable,
                                                  latency_prediction, latency_threshold);
            end
            if (normal_valid && normal_ready) exp_norm.push_back({normal_data, normal_header});
        end
    end

    task automatic send_bypass(input bypass_pkg::flit_type_t kind);
        @(posedge clk_quarter_rate);
        bypass_valid  <= 1'b1;
        bypass_data   <= {$random(seed), $random(seed)};
        bypass_header <= bypass_pkg::flit_header_t'({kind, 2'($random(seed)), 8'($random(seed))});
        @(negedge clk_quarter_rate);
        while (!bypass_ready) @(negedge clk_quarter_rate);
        @(posedge clk_quarter_rate);
        bypass_valid <= 1'b0;
    endtask

    task automatic send_normal();
        @(posedge clk_quarter_rate);
        normal_valid  <= 1'b1;
        normal_data   <= {$random(seed), $random(seed)};
        normal_header <= bypass_pkg::flit_header_t'(12'($random(seed)));
        @(negedge clk_quarter_rate);
        while (!normal_ready) @(negedge clk_quarter_rate);
        @(posedge clk_quarter_rate);
        normal_valid <= 1'b0;
    endtask

    // Open the output and wait until every expected flit is out
    task automatic drain_all();
        @(posedge clk_quarter_rate);
        bypass_valid <= 1'b0;
        normal_valid <= 1'b0;
        mux_ready    <= 1'b1;
        @(negedge clk_quarter_rate);
        while ((exp_byp.size() != 0) || (exp_norm.size() != 0) || mux_valid) begin
            @(negedge clk_quarter_rate);
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk_quarter_rate);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n = 1'b0;
        bypass_enable = 1'b0;
        hint_enable = 1'b0;
        latency_threshold = 8'd0;
        utilization_limit = 8'd100;
        latency_prediction = 8'd0;
        bypass_data = '0;
        bypass_header = '0;
        bypass_valid = 1'b0;
        normal_data = '0;
        normal_header = '0;
        normal_valid = 1'b0;
        mux_ready = 1'b0;
        order_mode = 0;
        repeat (15) @(posedge clk_quarter_rate);
        @(negedge clk_quarter_rate);
        check_equal(mux_valid, 0, "mux_valid in reset");
        check_equal({bypass_ready, normal_ready}, 0, "readies in reset");
        check_equal({bypass_packets_count, normal_packets_count}, 0, "counters in reset");
        check_equal(bypass_utilization_percent, 0, "utilization in reset");
        check_equal(active_priority, 0, "active_priority in reset");
        @(posedge clk_quarter_rate);
        rst_n <= 1'b1;

        // Offered traffic while disabled must not be taken
        @(posedge clk_quarter_rate);
        bypass_valid <= 1'b1;
        normal_valid <= 1'b1;
        repeat (8) @(posedge clk_quarter_rate);
        bypass_valid <= 1'b0;
        normal_valid <= 1'b0;
        bypass_enable <= 1'b1;

        repeat (random_cycles) begin
            @(posedge clk_quarter_rate);
            bypass_enable      <= (($random(seed) & 7) != 0);
            hint_enable        <= $random(seed);
            latency_threshold  <= $random(seed);
            latency_prediction <= $random(seed);
            utilization_limit  <= 8'({$random(seed)} % 101);
            bypass_valid       <= $random(seed);
            bypass_data        <= {$random(seed), $random(seed)};
            bypass_header      <= bypass_pkg::flit_header_t'(12'($random(seed)));
            normal_valid       <= $random(seed);
            normal_data        <= {$random(seed), $random(seed)};
            normal_header      <= bypass_pkg::flit_header_t'(12'($random(seed)));
            mux_ready          <= (($random(seed) & 3) != 0);
        end
        @(posedge clk_quarter_rate);
        bypass_enable <= 1'b1;
        drain_all();

        // Eligible bypass flits jump the queued normal ones
        @(posedge clk_quarter_rate);
        mux_ready <= 1'b0;
        hint_enable <= 1'b0;
        utilization_limit <= 8'd100;
        repeat (5) send_normal();
        for (int i = 0; i < 4; i++) begin
            send_bypass(i[0] ? bypass_pkg::flit_ctrl : bypass_pkg::flit_mgmt);
        end
        order_mode = 1;
        drain_all();
        order_mode = 0;

        // Throttled bypass flits wait behind normal traffic
        while (bypass_utilization_percent == 8'd0) @(negedge clk_quarter_rate);
        @(posedge clk_quarter_rate);
        utilization_limit <= 8'd0;
        mux_ready <= 1'b0;
        repeat (5) send_normal();
        repeat (4) send_bypass(bypass_pkg::flit_mgmt);
        order_mode = 2;
        drain_all();
        order_mode = 0;
        repeat (4) @(negedge clk_quarter_rate);

        $display("All checks passed");
        $finish;
    end

endmodule

/* vlog.f */
source/bypass_pkg.sv
source/flit_classifier.sv
source/flit_queue.sv
source/egress_arbiter.sv
source/bypass_monitor.sv
source/bypass_top.sv
bench/bypass_tb.sv
